/* verilog/spmm_consts.svh */
// Sizes and widths shared by every block of the sparse-dense multiplier
`ifndef SPMM_CONSTS_SVH
`define SPMM_CONSTS_SVH

// ====================
// Operands
// ====================
`define SPMM_DATA_W      8
`define SPMM_FEAT_IN     16
`define SPMM_FEAT_OUT    4
`define SPMM_COL_W       4

// Length 16 must fit, hence one bit more than the column index
`define SPMM_ROW_LEN_W   5
`define SPMM_NODE_W      8
`define SPMM_ACC_W       20

// ====================
// Buffering
// ====================
`define SPMM_INFO_DEPTH  4
`define SPMM_OUT_DEPTH   4

`endif

/* verilog/spmm_sparse_pkg.sv */
// Types of the sparse H stream and of the operations sent to the PE array
`include "spmm_consts.svh"

package spmm_sparse_pkg;

  // One nonzero entry of H
  typedef struct packed {
    logic [`SPMM_COL_W-1:0]         col;
    logic signed [`SPMM_DATA_W-1:0] val;
  } nz_entry_t;

  // Row descriptor, one per row of H
  typedef struct packed {
    logic [`SPMM_ROW_LEN_W-1:0] row_len;
    logic [`SPMM_NODE_W-1:0]    num_node;
    logic                       src_flag;
  } row_info_t;

  // Empty row travels as first and last with a zero value
  typedef struct packed {
    logic [`SPMM_COL_W-1:0]         col;
    logic signed [`SPMM_DATA_W-1:0] val;
    logic                           first;
    logic                           last;
  } pe_op_t;

endpackage

/* verilog/spmm_result_pkg.sv */
// Types of the weight rows and of the Wh result rows
`include "spmm_consts.svh"

package spmm_result_pkg;

  typedef logic signed [`SPMM_DATA_W-1:0] weight_t;
  typedef logic signed [`SPMM_ACC_W-1:0]  acc_t;

  // One row of W, lane j belongs to PE j
  typedef struct packed {
    weight_t [`SPMM_FEAT_OUT-1:0] lane;
  } wgt_row_t;

  // One row of Wh with the metadata of its descriptor
  typedef struct packed {
    acc_t [`SPMM_FEAT_OUT-1:0] sum;
    logic [`SPMM_NODE_W-1:0]   num_node;
    logic                      src_flag;
  } wh_row_t;

endpackage

/* verilog/spmm_fifo.sv */
// Synchronous FIFO for any payload type, with head-entry output and free-slot count
module spmm_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push_i,
  input  T           din_i,
  output logic       full_o,
  input  logic       pop_i,
  output T           dout_o,
  output logic       empty_o,
  output logic [2:0] free_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                mem [DEPTH];
  logic [AW-1:0]   wr_ptr_q;
  logic [AW-1:0]   rd_ptr_q;
  logic [2:0]      count_q;
  logic            do_push;
  logic            do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign full_o  = (count_q == 3'(DEPTH));
  assign empty_o = (count_q == 3'd0);
  assign free_o  = 3'(DEPTH) - count_q;
  assign dout_o  = mem[rd_ptr_q];

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  // Pointers wrap at DEPTH
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* verilog/row_sequencer.sv */
// Pairs each nonzero with the descriptor at the FIFO head and issues PE operations
`include "spmm_consts.svh"

module row_sequencer (
  input  logic                        clk,
  input  logic                        rst_n,
  // Nonzero stream
  input  logic                        nz_valid_i,
  output logic                        nz_ready_o,
  input  spmm_sparse_pkg::nz_entry_t  nz_i,
  // Descriptor FIFO head
  input  logic                        info_empty_i,
  input  spmm_sparse_pkg::row_info_t  info_i,
  output logic                        info_pop_o,
  // Operations to the PE array
  output logic                        op_valid_o,
  input  logic                        op_ready_i,
  output spmm_sparse_pkg::pe_op_t     op_o,
  output spmm_sparse_pkg::row_info_t  op_info_o
);

  logic [`SPMM_ROW_LEN_W-1:0] nz_cnt_q;
  logic                       have_info;
  logic                       empty_row;
  logic                       last_op;
  logic                       op_fire;

  // ====================
  // Row state
  // ====================
  assign have_info = !info_empty_i;
  assign empty_row = (info_i.row_len == '0);

  // Last nonzero of the row, or the single slot of an empty row
  assign last_op = empty_row || (nz_cnt_q == info_i.row_len - 1'b1);

  // ====================
  // Handshakes
  // ====================
  // An empty row needs no nonzero, so it issues on the descriptor alone
  assign op_valid_o = have_info && (empty_row || nz_valid_i);
  assign nz_ready_o = have_info && !empty_row && op_ready_i;
  assign op_fire    = op_valid_o && op_ready_i;
  assign info_pop_o = op_fire && last_op;

  // ====================
  // Operation fields
  // ====================
  always_comb begin
    op_o.first = (nz_cnt_q == '0);
    op_o.last  = last_op;
    if (empty_row) begin
      op_o.col = '0;
      op_o.val = '0;
    end else begin
      op_o.col = nz_i.col;
      op_o.val = nz_i.val;
    end
  end

  // Metadata rides along, the array samples it with every operation
  assign op_info_o = info_i;

  // Nonzeros issued so far in the current row
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nz_cnt_q <= '0;
    end else if (op_fire) begin
      if (last_op) begin
        nz_cnt_q <= '0;
      end else begin
        nz_cnt_q <= nz_cnt_q + 1'b1;
      end
    end
  end

endmodule

/* verilog/sparse_pe.sv */
// Processing element for one output column: weight memory and multiply-accumulate
`include "spmm_consts.svh"

module sparse_pe (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wgt_we_i,
  input  logic [`SPMM_COL_W-1:0]         wgt_addr_i,
  input  logic signed [`SPMM_DATA_W-1:0] wgt_i,
  input  logic                           op_fire_i,
  input  spmm_sparse_pkg::pe_op_t        op_i,
  output logic signed [`SPMM_ACC_W-1:0]  sum_o,
  output logic                           sum_valid_o
);

  logic signed [`SPMM_DATA_W-1:0]   wmem [`SPMM_FEAT_IN];
  logic signed [`SPMM_DATA_W-1:0]   wgt_q;
  logic signed [`SPMM_DATA_W-1:0]   val_q;
  logic                             first_q;
  logic                             last_q;
  logic                             s1_valid_q;
  logic signed [2*`SPMM_DATA_W-1:0] prod;
  logic signed [`SPMM_ACC_W-1:0]    acc_base;

  // Stage 1 reads the weight and delays the value to match
  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wmem[wgt_addr_i] <= wgt_i;
    end
    if (op_fire_i) begin
      wgt_q   <= wmem[op_i.col];
      val_q   <= op_i.val;
      first_q <= op_i.first;
      last_q  <= op_i.last;
    end
  end

  assign prod = wgt_q * val_q;

  // First op of a row starts from zero
  assign acc_base = first_q ? '0 : sum_o;

  // Stage 2 accumulates
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q  <= 1'b0;
      sum_valid_o <= 1'b0;
      sum_o       <= '0;
    end else begin
      s1_valid_q  <= op_fire_i;
      sum_valid_o <= s1_valid_q && last_q;
      if (s1_valid_q) begin
        sum_o <= acc_base + prod;
      end
    end
  end

endmodule

/* verilog/pe_array.sv */
// Four column PEs with metadata alignment and assembly of the Wh result row
`include "spmm_consts.svh"

module pe_array (
  input  logic                         clk,
  input  logic                         rst_n,
  // Weight writes, one lane per PE
  input  logic                         wgt_we_i,
  input  logic [`SPMM_COL_W-1:0]       wgt_addr_i,
  input  spmm_result_pkg::wgt_row_t    wgt_i,
  // Operations from the sequencer
  input  logic                         op_valid_i,
  output logic                         op_ready_o,
  input  spmm_sparse_pkg::pe_op_t      op_i,
  input  spmm_sparse_pkg::row_info_t   op_info_i,
  // Output FIFO side
  input  logic [2:0]                   out_free_i,
  output logic                         wh_push_o,
  output spmm_result_pkg::wh_row_t     wh_o
);

  import spmm_result_pkg::*;

  acc_t                      pe_sum [`SPMM_FEAT_OUT];
  logic [`SPMM_FEAT_OUT-1:0] pe_sum_valid;
  logic                      op_fire;
  logic [`SPMM_NODE_W-1:0]   node_s1_q;
  logic [`SPMM_NODE_W-1:0]   node_s2_q;
  logic                      flag_s1_q;
  logic                      flag_s2_q;

  // Room for the up to three rows that may still be in the pipeline
  assign op_ready_o = (out_free_i >= 3'd3);
  assign op_fire    = op_valid_i && op_ready_o;

  // ====================
  // Column PEs
  // ====================
  for (genvar g = 0; g < `SPMM_FEAT_OUT; g++) begin : g_pe
    sparse_pe i_sparse_pe (
      .clk         (clk),
      .rst_n       (rst_n),
      .wgt_we_i    (wgt_we_i),
      .wgt_addr_i  (wgt_addr_i),
      .wgt_i       (wgt_i.lane[g]),
      .op_fire_i   (op_fire),
      .op_i        (op_i),
      .sum_o       (pe_sum[g]),
      .sum_valid_o (pe_sum_valid[g])
    );
  end

  // Metadata follows the PE pipeline, two stages
  always_ff @(posedge clk) begin
    if (op_fire) begin
      node_s1_q <= op_info_i.num_node;
      flag_s1_q <= op_info_i.src_flag;
    end
    node_s2_q <= node_s1_q;
    flag_s2_q <= flag_s1_q;
  end

  // ====================
  // Result row
  // ====================
  assign wh_push_o = &pe_sum_valid;

  always_comb begin
    for (int j = 0; j < `SPMM_FEAT_OUT; j++) begin
      wh_o.sum[j] = pe_sum[j];
    end
    wh_o.num_node = node_s2_q;
    wh_o.src_flag = flag_s2_q;
  end

endmodule

/* verilog/spmm_top.sv */
// Sparse-times-dense multiplier Wh = H x W, first stage of the attention datapath
`include "spmm_consts.svh"

module spmm_top (
  input  logic                         clk,
  input  logic                         rst_n,
  // Nonzeros of H
  input  logic                         nz_valid_i,
  output logic                         nz_ready_o,
  input  spmm_sparse_pkg::nz_entry_t   nz_i,
  // Row descriptors of H
  input  logic                         info_valid_i,
  output logic                         info_ready_o,
  input  spmm_sparse_pkg::row_info_t   info_i,
  // W rows
  input  logic                         wgt_we_i,
  input  logic [`SPMM_COL_W-1:0]       wgt_addr_i,
  input  spmm_result_pkg::wgt_row_t    wgt_i,
  // Result rows
  output logic                         wh_valid_o,
  input  logic                         wh_ready_i,
  output spmm_result_pkg::wh_row_t     wh_o
);

  import spmm_sparse_pkg::*;
  import spmm_result_pkg::*;

  row_info_t  head_info;
  logic       info_full;
  logic       info_empty;
  logic       info_pop;
  logic       op_valid;
  logic       op_ready;
  pe_op_t     op;
  row_info_t  op_info;
  logic       wh_push;
  wh_row_t    wh_row;
  logic       out_empty;
  logic [2:0] out_free;

  assign info_ready_o = !info_full;
  assign wh_valid_o   = !out_empty;

  // ====================
  // Descriptor FIFO
  // ====================
  spmm_fifo #(.T(row_info_t), .DEPTH(`SPMM_INFO_DEPTH)) i_info_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (info_valid_i),
    .din_i   (info_i),
    .full_o  (info_full),
    .pop_i   (info_pop),
    .dout_o  (head_info),
    .empty_o (info_empty),
    .free_o  ()
  );

  row_sequencer i_row_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .nz_valid_i   (nz_valid_i),
    .nz_ready_o   (nz_ready_o),
    .nz_i         (nz_i),
    .info_empty_i (info_empty),
    .info_i       (head_info),
    .info_pop_o   (info_pop),
    .op_valid_o   (op_valid),
    .op_ready_i   (op_ready),
    .op_o         (op),
    .op_info_o    (op_info)
  );

  pe_array i_pe_array (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_i      (wgt_i),
    .op_valid_i (op_valid),
    .op_ready_o (op_ready),
    .op_i       (op),
    .op_info_i  (op_info),
    .out_free_i (out_free),
    .wh_push_o  (wh_push),
    .wh_o       (wh_row)
  );

  // ====================
  // Output FIFO
  // ====================
  spmm_fifo #(.T(wh_row_t), .DEPTH(`SPMM_OUT_DEPTH)) i_out_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (wh_push),
    .din_i   (wh_row),
    .full_o  (),
    .pop_i   (wh_ready_i),
    .dout_o  (wh_o),
    .empty_o (out_empty),
    .free_o  (out_free)
  );

endmodule

/* test/tb_clock.sv */
// Testbench clock and active-low reset generator
module tb_clock #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset held low for a fixed number of rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* test/spmm_tb.sv */
// Directed testbench for the sparse-dense multiplier with a reference model of H x W
`include "spmm_consts.svh"

module spmm_tb;

  import spmm_sparse_pkg::*;
  import spmm_result_pkg::*;

  localparam int TIMEOUT = 1000;

  logic                     clk;
  logic                     rst_n;
  logic                     nz_valid;
  logic                     nz_ready;
  nz_entry_t                nz;
  logic                     info_valid;
  logic                     info_ready;
  row_info_t                info;
  logic                     wgt_we;
  logic [`SPMM_COL_W-1:0]   wgt_addr;
  wgt_row_t                 wgt;
  logic                     wh_valid;
  logic                     wh_ready;
  wh_row_t                  wh;

  // Reference state
  int                       w_model [`SPMM_FEAT_IN][`SPMM_FEAT_OUT];
  logic [`SPMM_COL_W-1:0]   row_col [`SPMM_FEAT_IN];
  logic signed [7:0]        row_val [`SPMM_FEAT_IN];
  wh_row_t                  exp_q [$];
  logic [31:0]              lcg_state;
  int                       rows_checked;
  int                       mismatches;
  int                       other_errors;

  tb_clock i_tb_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  spmm_top i_spmm_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .nz_valid_i   (nz_valid),
    .nz_ready_o   (nz_ready),
    .nz_i         (nz),
    .info_valid_i (info_valid),
    .info_ready_o (info_ready),
    .info_i       (info),
    .wgt_we_i     (wgt_we),
    .wgt_addr_i   (wgt_addr),
    .wgt_i        (wgt),
    .wh_valid_o   (wh_valid),
    .wh_ready_i   (wh_ready),
    .wh_o         (wh)
  );

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic row_info_t make_info(input int len, input int node, input logic flag);
    row_info_t ri;
    ri.row_len  = len[`SPMM_ROW_LEN_W-1:0];
    ri.num_node = node[`SPMM_NODE_W-1:0];
    ri.src_flag = flag;
    return ri;
  endfunction

  // Sum of value times W[col][j] over the nonzeros of the row
  function automatic wh_row_t model_row(input row_info_t ri);
    wh_row_t m;
    int      acc;
    for (int j = 0; j < `SPMM_FEAT_OUT; j++) begin
      acc = 0;
      for (int k = 0; k < int'(ri.row_len); k++) begin
        acc += int'(row_val[k]) * w_model[row_col[k]][j];
      end
      m.sum[j] = acc_t'(acc);
    end
    m.num_node = ri.num_node;
    m.src_flag = ri.src_flag;
    return m;
  endfunction

  task automatic build_random_nz(input int n);
    logic [31:0] r;
    for (int k = 0; k < n; k++) begin
      r = lcg_next();
      row_col[k] = r[19:16];
      row_val[k] = r[31:24];
    end
  endtask

  task automatic write_weights();
    wgt_row_t    row;
    logic [31:0] r;
    for (int a = 0; a < `SPMM_FEAT_IN; a++) begin
      for (int j = 0; j < `SPMM_FEAT_OUT; j++) begin
        r = lcg_next();
        row.lane[j] = r[23:16];
        w_model[a][j] = int'(row.lane[j]);
      end
      @(posedge clk);
      wgt_we   <= 1'b1;
      wgt_addr <= 4'(a);
      wgt      <= row;
    end
    @(posedge clk);
    wgt_we <= 1'b0;
  endtask

  // Returns on the edge that completes the transfer
  task automatic hold_until_taken(input bit nz_side, input string what);
    int waited;
    bit taken;
    waited = 0;
    taken  = 1'b0;
    while (!taken && waited < TIMEOUT) begin
      @(negedge clk);
      taken = nz_side ? nz_ready : info_ready;
      waited++;
      if (!taken) begin
        @(posedge clk);
      end
    end
    if (!taken) begin
      other_errors++;
      $display("ERROR: %s was not accepted within %0d cycles", what, TIMEOUT);
    end
    @(posedge clk);
  endtask

  task automatic send_row(input row_info_t ri);
    nz_entry_t e;
    exp_q.push_back(model_row(ri));
    @(posedge clk);
    info_valid <= 1'b1;
    info       <= ri;
    hold_until_taken(1'b0, "row descriptor");
    info_valid <= 1'b0;
    for (int k = 0; k < int'(ri.row_len); k++) begin
      e.col = row_col[k];
      e.val = row_val[k];
      nz_valid <= 1'b1;
      nz       <= e;
      hold_until_taken(1'b1, "nonzero entry");
    end
    nz_valid <= 1'b0;
  endtask

  // ====================
  // Checks
  // ====================
  task automatic compare_wh(input wh_row_t got, input wh_row_t exp);
    rows_checked++;
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: got sums %0d %0d %0d %0d node %0d flag %b,",
               $time, got.sum[0], got.sum[1], got.sum[2], got.sum[3],
               got.num_node, got.src_flag);
      $display("  expected sums %0d %0d %0d %0d node %0d flag %b",
               exp.sum[0], exp.sum[1], exp.sum[2], exp.sum[3],
               exp.num_node, exp.src_flag);
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Takes one result row, with ready either steady or toggled by the LCG
  task automatic expect_row(input bit toggle_ready);
    wh_row_t     got;
    logic [31:0] r;
    int          waited;
    bit          done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < TIMEOUT) begin
      @(posedge clk);
      r = lcg_next();
      wh_ready <= toggle_ready ? r[20] : 1'b1;
      @(negedge clk);
      if (wh_valid && wh_ready) begin
        got  = wh;
        done = 1'b1;
      end
      waited++;
    end
    @(posedge clk);
    wh_ready <= 1'b0;
    if (!done) begin
      other_errors++;
      $display("ERROR: no result row arrived within %0d cycles", TIMEOUT);
    end else if (exp_q.size() == 0) begin
      other_errors++;
      $display("ERROR: result row arrived with no row outstanding");
    end else begin
      compare_wh(got, exp_q.pop_front());
    end
  endtask

  // ====================
  // Tests
  // ====================
  task automatic test_single_row();
    compare_flag(wh_valid, 1'b0, "wh_valid_o after reset");
    compare_flag(nz_ready, 1'b0, "nz_ready_o after reset");
    compare_flag(info_ready, 1'b1, "info_ready_o after reset");
    build_random_nz(3);
    row_col[0] = 4'd2;
    row_col[1] = 4'd7;
    row_col[2] = 4'd13;
    send_row(make_info(3, 5, 1'b1));
    expect_row(1'b0);
  endtask

  task automatic test_dense_then_sparse();
    build_random_nz(16);
    for (int k = 0; k < 16; k++) begin
      row_col[k] = 4'(k);
    end
    send_row(make_info(16, 17, 1'b0));
    build_random_nz(1);
    send_row(make_info(1, 18, 1'b1));
    repeat (2) expect_row(1'b0);
  endtask

  task automatic test_empty_row();
    fork
      begin
        build_random_nz(2);
        send_row(make_info(2, 30, 1'b0));
        send_row(make_info(0, 31, 1'b1));
        build_random_nz(4);
        send_row(make_info(4, 32, 1'b0));
      end
      begin
        repeat (3) expect_row(1'b0);
      end
    join
  endtask

  task automatic test_random_rows();
    logic [31:0] r;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          r = lcg_next();
          build_random_nz(int'(r[30:16]) % 17);
          send_row(make_info(int'(r[30:16]) % 17, int'(r[15:8]), r[3]));
        end
      end
      begin
        repeat (8) expect_row(1'b1);
      end
    join
  endtask

  task automatic test_backpressure();
    int stalled_for;
    int waited;
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          build_random_nz(3);
          send_row(make_info(3, 40 + i, i[0]));
        end
      end
      begin
        stalled_for = 0;
        waited      = 0;
        // wh_ready_i stays low until the inputs have stalled for a while
        while (stalled_for < 20 && waited < TIMEOUT) begin
          @(negedge clk);
          if ((nz_valid && !nz_ready) || (info_valid && !info_ready)) begin
            stalled_for++;
          end else begin
            stalled_for = 0;
          end
          waited++;
        end
        if (stalled_for < 20) begin
          other_errors++;
          $display("ERROR: input streams never stalled while wh_ready_i was low");
        end
        repeat (6) expect_row(1'b0);
      end
    join
  endtask

  task automatic test_metadata_extremes();
    fork
      begin
        build_random_nz(1);
        send_row(make_info(1, 0, 1'b0));
        send_row(make_info(1, 255, 1'b1));
        send_row(make_info(1, 0, 1'b1));
        send_row(make_info(1, 255, 1'b0));
      end
      begin
        repeat (4) expect_row(1'b0);
      end
    join
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    int waited;
    lcg_state    = 32'h18a3_9d71;
    rows_checked = 0;
    mismatches   = 0;
    other_errors = 0;
    nz_valid   <= 1'b0;
    nz         <= '0;
    info_valid <= 1'b0;
    info       <= '0;
    wgt_we     <= 1'b0;
    wgt_addr   <= '0;
    wgt        <= '0;
    wh_ready   <= 1'b0;
    waited = 0;
    while (!rst_n && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (!rst_n) begin
      other_errors++;
      $display("ERROR: reset was never released");
    end
    write_weights();
    test_single_row();
    test_dense_then_sparse();
    test_empty_row();
    test_random_rows();
    test_backpressure();
    test_metadata_extremes();
    $display("Summary: %0d rows checked, %0d mismatches, %0d other errors",
             rows_checked, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+verilog
verilog/spmm_sparse_pkg.sv
verilog/spmm_result_pkg.sv
verilog/spmm_fifo.sv
verilog/row_sequencer.sv
verilog/sparse_pe.sv
verilog/pe_array.sv
verilog/spmm_top.sv
test/tb_clock.sv
test/spmm_tb.sv

/* Bender.yml */
package:
  name: spmm

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/spmm_sparse_pkg.sv
      - verilog/spmm_result_pkg.sv
      - verilog/spmm_fifo.sv
      - verilog/row_sequencer.sv
      - verilog/sparse_pe.sv
      - verilog/pe_array.sv
      - verilog/spmm_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clock.sv
      - test/spmm_tb.sv
